/* logic/i2c_master_cfg.svh */
`ifndef I2C_MASTER_CFG_SVH
`define I2C_MASTER_CFG_SVH

// ---------------------------------------------------------------------------
// bus timing
// ---------------------------------------------------------------------------

// clk cycles per quarter of one scl period
`define I2C_QUARTER_CLKS 5

// quarter counter width, must hold I2C_QUARTER_CLKS-1
`define I2C_CNT_W 3

// ---------------------------------------------------------------------------
// transfer sizes
// ---------------------------------------------------------------------------

`define I2C_DATA_W    32   // burst data word
`define I2C_MAX_BYTES 4    // bytes per burst

`endif

/* logic/i2c_master_pkg.sv */
`include "i2c_master_cfg.svh"

package i2c_master_pkg;

    // transfer modes, same encoding as the host register field
    typedef enum logic [1:0] {
        write_only = 2'b00,
        read_only  = 2'b01,
        reg_write  = 2'b10,
        reg_read   = 2'b11
    } i2c_mode_e;

    typedef struct packed {
        i2c_mode_e               mode;
        logic [6:0]              slave_addr;
        logic [7:0]              reg_addr;
        logic [1:0]              burst_len;   // bytes minus one
        logic [`I2C_DATA_W-1:0]  tx_data;     // msb byte goes first
    } i2c_cmd_t;

    typedef struct packed {
        logic                    nack;        // transfer aborted
        logic [`I2C_DATA_W-1:0]  rx_data;
    } i2c_status_t;

    // ---------------------------------------------------------------------
    // byte on the wire, raw data or address frame
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;     // 1 = read
    } i2c_addr_byte_t;

    typedef union packed {
        logic [7:0]     raw;
        i2c_addr_byte_t addr;
    } i2c_byte_u;

    // one-cycle strobes on entry to each quarter of a bit slot
    typedef struct packed {
        logic q0;
        logic q1;
        logic q2;
        logic q3;
    } i2c_quarter_t;

    typedef enum logic [2:0] {
        ph_idle, ph_start, ph_rep_start, ph_stop, ph_bit_tx, ph_bit_rx, ph_bit_ack
    } i2c_phase_e;

endpackage

/* logic/i2c_bit_timer.sv */
`timescale 1ns/100ps
`include "i2c_master_cfg.svh"

module i2c_bit_timer
    import i2c_master_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         i_run,
    output i2c_quarter_t o_quarter,
    output logic         o_scl_gen
);

    logic [`I2C_CNT_W-1:0] cnt;
    logic [1:0]            qidx;   // current quarter of the slot
    logic                  entry;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt  <= '0;
            qidx <= 2'd0;
        end else if (!i_run) begin
            cnt  <= '0;     // parked at q0
            qidx <= 2'd0;
        end else if (cnt == `I2C_CNT_W'(`I2C_QUARTER_CLKS - 1)) begin
            cnt  <= '0;
            qidx <= qidx + 2'd1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // first cycle of a quarter
    assign entry = i_run & (cnt == '0);

    assign o_quarter.q0 = entry & (qidx == 2'd0);
    assign o_quarter.q1 = entry & (qidx == 2'd1);
    assign o_quarter.q2 = entry & (qidx == 2'd2);
    assign o_quarter.q3 = entry & (qidx == 2'd3);

    assign o_scl_gen = qidx[0] ^ qidx[1];   // high in q1 and q2

endmodule

/* logic/i2c_byte_shifter.sv */
`timescale 1ns/100ps

module i2c_byte_shifter
    import i2c_master_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  i2c_phase_e   i_phase,
    input  i2c_quarter_t i_quarter,
    input  logic         i_load,
    input  i2c_byte_u    i_load_byte,
    input  logic         i_sda,
    output logic         o_byte_done,
    output logic [7:0]   o_rx_byte,
    output logic         o_ack,
    output logic         o_sda_low
);

    logic [7:0] tx_reg;
    logic [7:0] rx_reg;
    logic [2:0] bit_cnt;
    logic       shifting;

    assign shifting  = (i_phase == ph_bit_tx) || (i_phase == ph_bit_rx);
    assign o_rx_byte = rx_reg;

    // msb first, ones fill in so the ack slot releases sda
    always_ff @(posedge clk) begin
        if (i_load)
            tx_reg <= i_load_byte.raw;
        else if (i_phase == ph_bit_tx && i_quarter.q0)
            tx_reg <= {tx_reg[6:0], 1'b1};
    end

    always_ff @(posedge clk) begin
        if (i_phase == ph_bit_rx && i_quarter.q1)
            rx_reg <= {rx_reg[6:0], i_sda};
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bit_cnt     <= 3'd0;
            o_byte_done <= 1'b0;
            o_ack       <= 1'b1;
        end else begin
            o_byte_done <= 1'b0;
            if (!shifting) begin
                bit_cnt <= 3'd0;
            end else if (i_quarter.q1) begin
                bit_cnt     <= bit_cnt + 3'd1;
                o_byte_done <= (bit_cnt == 3'd7);
            end
            if (i_phase == ph_bit_ack && i_quarter.q1)
                o_ack <= i_sda;   // 0 = ack
        end
    end

    // ---------------------------------------------------------------------
    // sda drive per phase
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_sda_low <= 1'b0;
        end else begin
            case (i_phase)
                ph_start: if (i_quarter.q2) o_sda_low <= 1'b1;   // falls under scl high
                ph_rep_start: begin
                    if (i_quarter.q0)
                        o_sda_low <= 1'b0;
                    else if (i_quarter.q2)
                        o_sda_low <= 1'b1;
                end
                ph_stop: begin
                    if (i_quarter.q0)
                        o_sda_low <= 1'b1;
                    else if (i_quarter.q2)
                        o_sda_low <= 1'b0;   // rises under scl high
                end
                ph_bit_tx, ph_bit_ack: if (i_quarter.q0) o_sda_low <= ~tx_reg[7];
                default: o_sda_low <= 1'b0;
            endcase
        end
    end

endmodule

/* logic/i2c_data_buffer.sv */
`timescale 1ns/100ps
`include "i2c_master_cfg.svh"

module i2c_data_buffer
    import i2c_master_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_capture,
    input  logic [`I2C_DATA_W-1:0] i_cmd_data,
    input  logic [1:0]             i_byte_idx,
    input  logic                   i_rx_store,
    input  logic [7:0]             i_rx_byte,
    output i2c_byte_u              o_tx_byte,
    output logic [`I2C_DATA_W-1:0] o_rx_data
);

    logic [`I2C_DATA_W-1:0] tx_word;
    logic [1:0]             lane;

    // byte 0 sits in the top lane
    assign lane = 2'(`I2C_MAX_BYTES - 1) - i_byte_idx;

    always_ff @(posedge clk) begin
        if (i_capture)
            tx_word <= i_cmd_data;
    end

    assign o_tx_byte.raw = tx_word[lane*8 +: 8];

    // ---------------------------------------------------------------------
    // received bytes, unread lanes stay zero
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_rx_data <= '0;
        end else if (i_capture) begin
            o_rx_data <= '0;   // fresh status per command
        end else if (i_rx_store) begin
            o_rx_data[lane*8 +: 8] <= i_rx_byte;
        end
    end

endmodule

/* logic/i2c_ctrl.sv */
`timescale 1ns/100ps

module i2c_ctrl
    import i2c_master_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         i_start,
    input  i2c_mode_e    i_mode,
    input  logic [1:0]   i_burst_len,
    input  logic [6:0]   i_slave_addr,
    input  logic [7:0]   i_reg_addr,
    input  i2c_byte_u    i_tx_byte,
    input  i2c_quarter_t i_quarter,
    input  logic         i_byte_done,
    input  logic         i_ack,
    output logic         o_ready,
    output logic         o_done,
    output logic         o_nack,
    output logic         o_capture,
    output logic         o_timer_run,
    output i2c_phase_e   o_phase,
    output logic         o_load,
    output i2c_byte_u    o_load_byte,
    output logic [1:0]   o_byte_idx,
    output logic         o_rx_store,
    output logic         o_scl_cond
);

    typedef enum logic [2:0] {
        st_idle, st_start, st_tx, st_tx_ack, st_rx, st_rx_ack, st_rep_start, st_stop
    } state_e;

    // what the current tx byte is
    typedef enum logic [1:0] {k_addr, k_reg, k_data} kind_e;

    state_e     state, state_n;
    kind_e      kind, kind_n;
    logic       addr_rw, addr_rw_n;
    i2c_mode_e  mode;
    logic [1:0] burst_len;
    logic [6:0] slave_addr;
    logic [7:0] reg_addr;
    logic [1:0] idx;
    logic       more;       // another data byte follows
    logic       byte_fin;   // 8 bits done, leave at slot end
    logic       accept;

    assign accept      = i_start & o_ready;
    assign o_capture   = accept;
    assign o_ready     = (state == st_idle) & ~o_done;
    assign o_timer_run = (state != st_idle);
    assign o_byte_idx  = idx;
    assign o_rx_store  = (state == st_rx) & i_byte_done;

    always_comb begin
        case (state)
            st_start:            o_phase = ph_start;
            st_tx:               o_phase = ph_bit_tx;
            st_rx:               o_phase = ph_bit_rx;
            st_tx_ack, st_rx_ack: o_phase = ph_bit_ack;
            st_rep_start:        o_phase = ph_rep_start;
            st_stop:             o_phase = ph_stop;
            default:             o_phase = ph_idle;
        endcase
    end

    // ---------------------------------------------------------------------
    // next slot, decided on the last quarter of the current one
    // ---------------------------------------------------------------------
    always_comb begin
        state_n   = state;
        kind_n    = kind;
        addr_rw_n = addr_rw;
        case (state)
            st_idle: if (accept) state_n = st_start;
            st_start: if (i_quarter.q3) begin
                state_n   = st_tx;
                kind_n    = k_addr;
                addr_rw_n = (mode == read_only);
            end
            st_tx: if (i_quarter.q3 && byte_fin) state_n = st_tx_ack;
            st_tx_ack: if (i_quarter.q3) begin
                if (i_ack) begin
                    state_n = st_stop;   // slave nack, abort
                end else begin
                    case (kind)
                        k_addr: begin
                            if (addr_rw) begin
                                state_n = st_rx;
                            end else begin
                                state_n = st_tx;
                                kind_n  = (mode == write_only) ? k_data : k_reg;
                            end
                        end
                        k_reg: begin
                            if (mode == reg_read) begin
                                state_n = st_rep_start;
                            end else begin
                                state_n = st_tx;
                                kind_n  = k_data;
                            end
                        end
                        default: state_n = more ? st_tx : st_stop;
                    endcase
                end
            end
            st_rep_start: if (i_quarter.q3) begin
                state_n   = st_tx;
                kind_n    = k_addr;
                addr_rw_n = 1'b1;
            end
            st_rx: if (i_quarter.q3 && byte_fin) state_n = st_rx_ack;
            st_rx_ack: if (i_quarter.q3) state_n = more ? st_rx : st_stop;
            st_stop: if (i_quarter.q3) state_n = st_idle;
            default: state_n = st_idle;
        endcase
    end

    // shifter load on entry to a tx byte or a master ack slot
    assign o_load = (state_n != state) && (state_n == st_tx || state_n == st_rx_ack);

    always_comb begin
        o_load_byte.raw = i_tx_byte.raw;
        if (state_n == st_rx_ack) begin
            o_load_byte.raw = more ? 8'h00 : 8'hff;   // nack the last byte
        end else if (kind_n == k_addr) begin
            o_load_byte.addr.addr = slave_addr;
            o_load_byte.addr.rw   = addr_rw_n;
        end else if (kind_n == k_reg) begin
            o_load_byte.raw = reg_addr;
        end
    end

    // command fields held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            mode       <= i_mode;
            burst_len  <= i_burst_len;
            slave_addr <= i_slave_addr;
            reg_addr   <= i_reg_addr;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= st_idle;
            kind     <= k_addr;
            addr_rw  <= 1'b0;
            idx      <= 2'd0;
            more     <= 1'b0;
            byte_fin <= 1'b0;
            o_done   <= 1'b0;
            o_nack   <= 1'b0;
        end else begin
            state   <= state_n;
            kind    <= kind_n;
            addr_rw <= addr_rw_n;
            o_done  <= (state == st_stop) & i_quarter.q3;
            if (accept) begin
                idx    <= 2'd0;
                o_nack <= 1'b0;
            end else if (state == st_tx_ack && state_n == st_stop && i_ack) begin
                o_nack <= 1'b1;
            end
            // data byte count against the burst length
            if (i_byte_done && (state == st_rx || (state == st_tx && kind == k_data))) begin
                more <= (idx != burst_len);
                if (idx != burst_len)
                    idx <= idx + 2'd1;
            end
            if (i_byte_done)
                byte_fin <= 1'b1;
            else if (state_n != state)
                byte_fin <= 1'b0;
        end
    end

    // scl level outside bit slots
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            o_scl_cond <= 1'b1;
        end else begin
            case (o_phase)
                ph_idle:  o_scl_cond <= 1'b1;
                ph_start: if (i_quarter.q3) o_scl_cond <= 1'b0;
                ph_rep_start: begin
                    if (i_quarter.q1)
                        o_scl_cond <= 1'b1;
                    else if (i_quarter.q3)
                        o_scl_cond <= 1'b0;
                end
                ph_stop:  if (i_quarter.q1) o_scl_cond <= 1'b1;
                default:  o_scl_cond <= 1'b0;   // low when a bit slot hands over
            endcase
        end
    end

endmodule

/* logic/i2c_master_top.sv */
`timescale 1ns/100ps
`include "i2c_master_cfg.svh"

module i2c_master_top
    import i2c_master_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        i_start,
    input  i2c_cmd_t    i_cmd,
    output logic        o_ready,
    output logic        o_done,
    output i2c_status_t o_status,
    output logic        o_scl,
    inout  wire         io_sda
);

    logic                   capture;
    logic                   timer_run;
    i2c_quarter_t           quarter;
    logic                   scl_gen;
    logic                   scl_cond;
    i2c_phase_e             phase;
    logic                   load;
    i2c_byte_u              load_byte;
    logic [1:0]             byte_idx;
    logic                   rx_store;
    logic                   byte_done;
    logic [7:0]             rx_byte;
    logic                   ack;
    logic                   sda_low;
    logic                   sda_in;
    logic                   nack;
    i2c_byte_u              tx_byte;
    logic [`I2C_DATA_W-1:0] rx_data;
    logic                   bit_phase;

    // ---------------------------------------------------------------------
    // pads
    // ---------------------------------------------------------------------
    assign io_sda = sda_low ? 1'b0 : 1'bz;   // open drain with the pull-up off chip
    assign sda_in = io_sda;

    // generated clock in bit slots and the sequencer level elsewhere
    assign bit_phase = phase inside {ph_bit_tx, ph_bit_rx, ph_bit_ack};
    assign o_scl     = bit_phase ? scl_gen : scl_cond;

    assign o_status.nack    = nack;
    assign o_status.rx_data = rx_data;

    i2c_ctrl i2c_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_mode       (i_cmd.mode),
        .i_burst_len  (i_cmd.burst_len),
        .i_slave_addr (i_cmd.slave_addr),
        .i_reg_addr   (i_cmd.reg_addr),
        .i_tx_byte    (tx_byte),
        .i_quarter    (quarter),
        .i_byte_done  (byte_done),
        .i_ack        (ack),
        .o_ready      (o_ready),
        .o_done       (o_done),
        .o_nack       (nack),
        .o_capture    (capture),
        .o_timer_run  (timer_run),
        .o_phase      (phase),
        .o_load       (load),
        .o_load_byte  (load_byte),
        .o_byte_idx   (byte_idx),
        .o_rx_store   (rx_store),
        .o_scl_cond   (scl_cond)
    );

    i2c_bit_timer i2c_bit_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .i_run     (timer_run),
        .o_quarter (quarter),
        .o_scl_gen (scl_gen)
    );

    i2c_byte_shifter i2c_byte_shifter_inst (
        .clk         (clk),
        .reset       (reset),
        .i_phase     (phase),
        .i_quarter   (quarter),
        .i_load      (load),
        .i_load_byte (load_byte),
        .i_sda       (sda_in),
        .o_byte_done (byte_done),
        .o_rx_byte   (rx_byte),
        .o_ack       (ack),
        .o_sda_low   (sda_low)
    );

    i2c_data_buffer i2c_data_buffer_inst (
        .clk        (clk),
        .reset      (reset),
        .i_capture  (capture),
        .i_cmd_data (i_cmd.tx_data),
        .i_byte_idx (byte_idx),
        .i_rx_store (rx_store),
        .i_rx_byte  (rx_byte),
        .o_tx_byte  (tx_byte),
        .o_rx_data  (rx_data)
    );

endmodule

/* sim/i2c_slave_model.sv */
`timescale 1ns/100ps

module i2c_slave_model (
    input  logic        i_scl,
    inout  wire         io_sda,
    input  logic [6:0]  i_addr,
    input  logic        i_addr_ack,   // 0 = nack own address
    input  logic [31:0] i_rd_data     // read bytes with the msb byte first
);

    logic [7:0] log_byte [0:15];      // bytes seen from the master
    logic       log_rs   [0:15];      // byte followed a repeated start
    int         log_cnt;
    int         rd_sent;
    int         bit_cnt;              // rising scl edges in this byte
    logic       active;
    logic       in_frame;
    logic       rs_flag;
    logic       first;                // address byte of the frame
    logic       rw;
    logic       sending;
    logic       acked;                // last ack on the bus (1 = ack)
    logic       sda_drive;
    logic [7:0] rx_sr;
    logic [7:0] tx_sr;

    assign io_sda = sda_drive ? 1'b0 : 1'bz;

    initial begin
        log_cnt   = 0;
        rd_sent   = 0;
        bit_cnt   = 0;
        active    = 1'b0;
        in_frame  = 1'b0;
        rs_flag   = 1'b0;
        first     = 1'b0;
        rw        = 1'b0;
        sending   = 1'b0;
        acked     = 1'b0;
        sda_drive = 1'b0;
    end

    // ------------------------------------------------------------------------
    // start and stop conditions
    // ------------------------------------------------------------------------
    always @(negedge io_sda) begin
        if (i_scl === 1'b1) begin
            if (!in_frame)
                log_cnt = 0;      // fresh transfer
            rs_flag   = in_frame;
            in_frame  = 1'b1;
            active    = 1'b1;
            first     = 1'b1;
            rw        = 1'b0;
            sending   = 1'b0;
            bit_cnt   = 0;
            rd_sent   = 0;
            sda_drive = 1'b0;
        end
    end

    always @(posedge io_sda) begin
        if (i_scl === 1'b1 && in_frame) begin
            in_frame  = 1'b0;
            active    = 1'b0;
            sda_drive = 1'b0;
        end
    end

    // sample on rising scl
    always @(posedge i_scl) begin
        if (active) begin
            if (bit_cnt < 8 && !sending)
                rx_sr = {rx_sr[6:0], io_sda};
            else if (bit_cnt == 8 && sending)
                acked = (io_sda == 1'b0);   // master ack
            bit_cnt = bit_cnt + 1;
        end
    end

    // ------------------------------------------------------------------------
    // drive on falling scl
    // ------------------------------------------------------------------------
    always @(negedge i_scl) begin
        if (active) begin
            if (bit_cnt == 9) begin
                bit_cnt = 0;
                first   = 1'b0;
                if (!acked) begin
                    sending   = 1'b0;     // only listens until stop
                    sda_drive = 1'b0;
                end else if (rw) begin
                    sending   = 1'b1;
                    tx_sr     = i_rd_data[31 - 8*rd_sent -: 8];
                    rd_sent   = rd_sent + 1;
                    sda_drive = ~tx_sr[7];
                end else begin
                    sda_drive = 1'b0;
                end
            end else if (bit_cnt == 8) begin
                if (sending) begin
                    sda_drive = 1'b0;     // master owns the ack bit
                end else begin
                    log_byte[log_cnt] = rx_sr;
                    log_rs[log_cnt]   = rs_flag;
                    log_cnt           = log_cnt + 1;
                    rs_flag           = 1'b0;
                    if (first) begin
                        rw    = rx_sr[0];
                        acked = (rx_sr[7:1] == i_addr) && i_addr_ack;
                    end
                    sda_drive = acked;    // later bytes follow the address ack
                end
            end else if (sending && bit_cnt != 0) begin
                tx_sr     = {tx_sr[6:0], 1'b1};
                sda_drive = ~tx_sr[7];
            end
        end
    end

endmodule

/* sim/tb_i2c_master.sv */
`timescale 1ns/100ps
`include "i2c_master_cfg.svh"

module tb_i2c_master
    import i2c_master_pkg::*;
();

    localparam logic [6:0] SLAVE_ADDR = 7'h51;
    localparam int SLOT_CLKS  = 4 * `I2C_QUARTER_CLKS;
    // worst case slots per test: write 47, reg write 38, reg read 57, read 20, nack 11
    localparam int TEST_SLOTS = 47 + 38 + 57 + 20 + 11;
    localparam int LIMIT      = TEST_SLOTS * SLOT_CLKS + 500;

    logic        clk;
    logic        reset;
    logic        start;
    i2c_cmd_t    cmd;
    logic        ready;
    logic        done;
    i2c_status_t status;
    logic        scl;
    wire         sda;
    logic [6:0]  slv_addr;
    logic        slv_ack;
    logic [31:0] slv_rd_data;
    logic [31:0] seed;
    int          cycle_cnt;

    pullup (sda);

    i2c_master_top i2c_master_top_inst (
        .clk      (clk),
        .reset    (reset),
        .i_start  (start),
        .i_cmd    (cmd),
        .o_ready  (ready),
        .o_done   (done),
        .o_status (status),
        .o_scl    (scl),
        .io_sda   (sda)
    );

    i2c_slave_model slave_inst (
        .i_scl      (scl),
        .io_sda     (sda),
        .i_addr     (slv_addr),
        .i_addr_ack (slv_ack),
        .i_rd_data  (slv_rd_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            abort_run();
        end
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function i2c_byte_u addr_byte(input logic [6:0] a, input logic rd);
        i2c_byte_u b;
        b.addr.addr = a;
        b.addr.rw   = rd;
        return b;
    endfunction

    function i2c_byte_u data_byte(input logic [7:0] v);
        i2c_byte_u b;
        b.raw = v;
        return b;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task abort_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_status(input string name, input i2c_status_t got,
                                  input i2c_status_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string name, input i2c_byte_u got, input i2c_byte_u exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_logged(input int idx, input i2c_byte_u exp, input logic rs);
        compare_byte($sformatf("log_byte[%0d]", idx), slave_inst.log_byte[idx], exp);
        compare_bit($sformatf("log_rs[%0d]", idx), slave_inst.log_rs[idx], rs);
    endtask

    // one full host handshake, status taken in the done cycle
    task automatic run_command(input i2c_cmd_t c, output i2c_status_t st);
        while (ready !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        cmd   <= c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        compare_bit("o_ready", ready, 1'b0);
        do
            @(negedge clk);
        while (done !== 1'b1);
        st = status;
        @(negedge clk);
        compare_bit("o_done", done, 1'b0);     // single cycle pulse
        compare_bit("o_ready", ready, 1'b1);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic check_reset_state();
        i2c_status_t exp;
        exp = '0;
        compare_bit("o_ready", ready, 1'b1);
        compare_bit("o_scl", scl, 1'b1);
        compare_bit("io_sda", sda, 1'b1);
        compare_status("o_status", status, exp);
        repeat (8) begin
            @(negedge clk);
            compare_bit("o_done", done, 1'b0);
        end
    endtask

    task automatic test_write_only();
        i2c_cmd_t    c;
        i2c_status_t st;
        i2c_status_t exp;
        int          k;
        c            = '0;
        c.mode       = write_only;
        c.slave_addr = SLAVE_ADDR;
        c.burst_len  = 2'd3;
        c.tx_data    = next_rand();
        run_command(c, st);
        exp = '0;
        compare_status("o_status", st, exp);
        compare_count("log_cnt", slave_inst.log_cnt, 5);
        check_logged(0, addr_byte(SLAVE_ADDR, 1'b0), 1'b0);
        for (k = 0; k < 4; k++)
            check_logged(k + 1, data_byte(c.tx_data[31 - 8*k -: 8]), 1'b0);
    endtask

    task automatic test_reg_write();
        i2c_cmd_t    c;
        i2c_status_t st;
        i2c_status_t exp;
        logic [31:0] r;
        r            = next_rand();
        c            = '0;
        c.mode       = reg_write;
        c.slave_addr = SLAVE_ADDR;
        c.reg_addr   = r[7:0];
        c.burst_len  = 2'd1;
        c.tx_data    = next_rand();
        run_command(c, st);
        exp = '0;
        compare_status("o_status", st, exp);
        compare_count("log_cnt", slave_inst.log_cnt, 4);
        check_logged(0, addr_byte(SLAVE_ADDR, 1'b0), 1'b0);
        check_logged(1, data_byte(c.reg_addr), 1'b0);
        check_logged(2, data_byte(c.tx_data[31:24]), 1'b0);
        check_logged(3, data_byte(c.tx_data[23:16]), 1'b0);
    endtask

    task automatic test_reg_read();
        i2c_cmd_t    c;
        i2c_status_t st;
        i2c_status_t exp;
        logic [31:0] r;
        r            = next_rand();
        slv_rd_data  = next_rand();
        c            = '0;
        c.mode       = reg_read;
        c.slave_addr = SLAVE_ADDR;
        c.reg_addr   = r[15:8];
        c.burst_len  = 2'd2;
        c.tx_data    = next_rand();
        run_command(c, st);
        exp.nack    = 1'b0;
        exp.rx_data = {slv_rd_data[31:8], 8'h00};   // lowest lane unread
        compare_status("o_status", st, exp);
        compare_count("log_cnt", slave_inst.log_cnt, 3);
        check_logged(0, addr_byte(SLAVE_ADDR, 1'b0), 1'b0);
        check_logged(1, data_byte(c.reg_addr), 1'b0);
        check_logged(2, addr_byte(SLAVE_ADDR, 1'b1), 1'b1);
        compare_count("rd_sent", slave_inst.rd_sent, 3);
        compare_bit("master ack on last byte", slave_inst.acked, 1'b0);
    endtask

    task automatic test_read_only();
        i2c_cmd_t    c;
        i2c_status_t st;
        i2c_status_t exp;
        slv_rd_data  = next_rand();
        c            = '0;
        c.mode       = read_only;
        c.slave_addr = SLAVE_ADDR;
        c.burst_len  = 2'd0;
        run_command(c, st);
        exp.nack    = 1'b0;
        exp.rx_data = {slv_rd_data[31:24], 24'h0};
        compare_status("o_status", st, exp);
        compare_count("log_cnt", slave_inst.log_cnt, 1);
        check_logged(0, addr_byte(SLAVE_ADDR, 1'b1), 1'b0);
        compare_count("rd_sent", slave_inst.rd_sent, 1);
        compare_bit("master ack on last byte", slave_inst.acked, 1'b0);
    endtask

    task automatic test_addr_nack();
        i2c_cmd_t    c;
        i2c_status_t st;
        i2c_status_t exp;
        slv_ack      = 1'b0;
        c            = '0;
        c.mode       = write_only;
        c.slave_addr = SLAVE_ADDR;
        c.burst_len  = 2'd2;
        c.tx_data    = next_rand();
        run_command(c, st);
        exp.nack    = 1'b1;
        exp.rx_data = '0;
        compare_status("o_status", st, exp);
        compare_count("log_cnt", slave_inst.log_cnt, 1);   // address only
        check_logged(0, addr_byte(SLAVE_ADDR, 1'b0), 1'b0);
        slv_ack = 1'b1;
    endtask

    initial begin
        reset       = 1'b0;
        start       = 1'b0;
        cmd         = '0;
        slv_addr    = SLAVE_ADDR;
        slv_ack     = 1'b1;
        slv_rd_data = '0;
        seed        = 32'd25403;
        cycle_cnt   = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_reset_state();
        test_write_only();
        test_reg_write();
        test_reg_read();
        test_read_only();
        test_addr_nack();
        $display("** PASS **");
        $finish;
    end

endmodule

/* i2c_master.f */
+incdir+logic
logic/i2c_master_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_byte_shifter.sv
logic/i2c_data_buffer.sv
logic/i2c_ctrl.sv
logic/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - include_dirs:
      - logic
    files:
      - logic/i2c_master_pkg.sv
      - logic/i2c_bit_timer.sv
      - logic/i2c_byte_shifter.sv
      - logic/i2c_data_buffer.sv
      - logic/i2c_ctrl.sv
      - logic/i2c_master_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/i2c_slave_model.sv
      - sim/tb_i2c_master.sv
